//--- vlog.f
rtl/fight_pkg.sv
rtl/sprite_ram.sv
rtl/player_fetch.sv
rtl/hud_boxes.sv
rtl/pixel_compositor.sv
rtl/fight_renderer.sv
tb/clock_gen.sv
tb/tb_fight_renderer.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_fight_renderer
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' vlog.f)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) vlog.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f vlog.f

run: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/tb_fight_renderer.sv
`default_nettype none

module tb_fight_renderer;

  localparam int CYCLE_LIMIT = 8192 * 3 + 4000 + 200; // Upload, scenes, margin

  logic                          clk;
  logic                          reset;
  fight_pkg::pixel_pos_t         pixel_pos;
  fight_pkg::player_t            p1;
  fight_pkg::player_t            p2;
  fight_pkg::game_state_t        game_state;
  fight_pkg::wb_req_t            wb_req;
  fight_pkg::wb_rsp_t            wb_rsp;
  logic [fight_pkg::COLOR_W-1:0] pixel_data;

  integer                        seed;
  int                            err_mismatch = 0;
  int                            err_other = 0;
  int                            cycle_count = 0;
  logic [7:0]                    sprite_model [0:8191]; // Mirror of the sprite memory
  logic [7:0]                    exp_q [$];             // Pixels in flight
  string                         name_q [$];
  logic [31:0]                   rnd;
  logic [7:0]                    wr_byte;
  logic [7:0]                    rd_byte;
  logic [12:0]                   rd_adr;
  fight_pkg::player_t            pa;
  fight_pkg::player_t            pb;
  fight_pkg::pixel_pos_t         pos;
  fight_pkg::game_state_t        st;
  int                            row_top;
  int                            slot_x;
  int                            k;
  fight_pkg::game_state_t        other_states [0:4] = '{fight_pkg::S_IDLE,
      fight_pkg::S_COUNTDOWN, fight_pkg::S_P1_WIN, fight_pkg::S_P2_WIN, fight_pkg::S_EQ};

  clock_gen i_clock_gen (.clk(clk), .reset(reset));

  fight_renderer i_dut (
    .clk        (clk),
    .reset      (reset),
    .pixel_pos  (pixel_pos),
    .p1         (p1),
    .p2         (p2),
    .game_state (game_state),
    .wb_req     (wb_req),
    .wb_rsp     (wb_rsp),
    .pixel_data (pixel_data)
  );

  function automatic int rand_below(input int n);
    return int'({$random(seed)} % n);
  endfunction

  function automatic logic [9:0] clamp_coord(input int v, input int hi);
    if (v < 0) return 10'd0;
    if (v > hi) return 10'(hi);
    return 10'(v);
  endfunction

  function automatic fight_pkg::pixel_pos_t rand_pos();
    fight_pkg::pixel_pos_t p;
    p.x = 10'(rand_below(fight_pkg::SCREEN_W));
    p.y = 10'(rand_below(fight_pkg::SCREEN_H));
    return p;
  endfunction

  function automatic fight_pkg::player_t rand_player(input logic any_pose);
    fight_pkg::player_t pl;
    pl.x      = 10'(rand_below(fight_pkg::SCREEN_W - fight_pkg::SPRITE_DIM + 1));
    pl.y      = 10'(rand_below(fight_pkg::SCREEN_H - fight_pkg::SPRITE_DIM + 1));
    pl.pose   = any_pose ? fight_pkg::pose_t'(4'(rand_below(16))) : fight_pkg::pose_t'(4'd15);
    pl.health = 3'(rand_below(5));
    pl.block  = 3'(rand_below(5));
    return pl;
  endfunction

  function automatic logic sprite_hit(input fight_pkg::pixel_pos_t p,
                                      input fight_pkg::player_t pl);
    return int'(pl.pose) < fight_pkg::POSE_COUNT
        && int'(p.x) >= int'(pl.x) && int'(p.x) < int'(pl.x) + fight_pkg::SPRITE_DIM
        && int'(p.y) >= int'(pl.y) && int'(p.y) < int'(pl.y) + fight_pkg::SPRITE_DIM;
  endfunction

  // Frame pixel index, 4x4 screen pixels per memory pixel
  function automatic int sprite_index(input fight_pkg::pixel_pos_t p,
                                      input fight_pkg::player_t pl, input int sel);
    int frame;
    int row;
    int col;
    frame = fight_pkg::FRAME_DIM * fight_pkg::FRAME_DIM;
    row   = (int'(p.y) - int'(pl.y)) / 4;
    col   = (int'(p.x) - int'(pl.x)) / 4;
    return sel * 16 * frame + int'(pl.pose) * frame + row * fight_pkg::FRAME_DIM + col;
  endfunction

  function automatic logic box_lit(input fight_pkg::pixel_pos_t p, input int top,
                                   input int cnt1, input int cnt2);
    int left1;
    int left2;
    logic lit;
    lit = 1'b0;
    if (int'(p.y) >= top && int'(p.y) < top + fight_pkg::BOX_SIZE) begin
      for (int s = 0; s < fight_pkg::BOX_SLOTS; s++) begin
        left1 = fight_pkg::BOX_OFFSET + s * fight_pkg::BOX_PITCH;
        left2 = fight_pkg::SCREEN_W - fight_pkg::BOX_OFFSET - fight_pkg::BOX_SIZE
                - s * fight_pkg::BOX_PITCH;
        if (cnt1 > s && int'(p.x) >= left1 && int'(p.x) < left1 + fight_pkg::BOX_SIZE) lit = 1'b1;
        if (cnt2 > s && int'(p.x) >= left2 && int'(p.x) < left2 + fight_pkg::BOX_SIZE) lit = 1'b1;
      end
    end
    return lit;
  endfunction

  function automatic logic [7:0] model_pixel(input fight_pkg::pixel_pos_t p,
      input fight_pkg::player_t a, input fight_pkg::player_t b, input fight_pkg::game_state_t s);
    logic [7:0] px;
    if (s != fight_pkg::S_FIGHT) return fight_pkg::BG_COLOR;
    if (box_lit(p, fight_pkg::BOX_OFFSET, int'(a.health), int'(b.health)))
      return fight_pkg::HEART_COLOR;
    if (box_lit(p, fight_pkg::SCREEN_H - fight_pkg::BOX_OFFSET - fight_pkg::BOX_SIZE,
                int'(a.block), int'(b.block)))
      return fight_pkg::BLOCK_COLOR;
    if (sprite_hit(p, a)) begin
      px = sprite_model[13'(sprite_index(p, a, 0))];
      if (px != fight_pkg::TRANSPARENT_COLOR) return px; // Player 1 on top
    end
    if (sprite_hit(p, b)) begin
      px = sprite_model[13'(sprite_index(p, b, 1))];
      if (px != fight_pkg::TRANSPARENT_COLOR) return px;
    end
    return fight_pkg::TRANSPARENT_COLOR;
  endfunction

  task automatic check_pixel(input string name, input logic [7:0] exp_px);
    assert (pixel_data === exp_px) else begin
      err_mismatch++;
      $display("MISMATCH %s: expected %02h, actual %02h", name, exp_px, pixel_data);
    end
  endtask

  // One Wishbone classic access with the request held over the edge after the ack
  task automatic bus_access(input logic we, input logic [12:0] adr, input logic [7:0] dat,
                            output logic [7:0] rdata);
    int   waited;
    logic got;
    waited     = 0;
    got        = 1'b0;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat_w = dat;
    while (!got && waited < 8) begin
      @(posedge clk);
      #1;
      waited++;
      got = wb_rsp.ack;
    end
    assert (got) else begin
      err_other++;
      $display("No ack came for the bus access at address %h", adr);
    end
    rdata = wb_rsp.dat_r;
    @(posedge clk); // Host takes the ack here, request still up
    #1;
    assert (!wb_rsp.ack) else begin
      err_other++;
      $display("A second ack came for the bus access at address %h", adr);
    end
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
  endtask

  task automatic pixel_step(input fight_pkg::pixel_pos_t p, input fight_pkg::player_t a,
                            input fight_pkg::player_t b, input fight_pkg::game_state_t s,
                            input string name);
    logic [7:0] exp_px;
    string      exp_name;
    @(posedge clk);
    #1;
    if (exp_q.size() == 2) begin // Oldest pixel has left the pipeline
      exp_px   = exp_q.pop_front();
      exp_name = name_q.pop_front();
      check_pixel(exp_name, exp_px);
    end
    pixel_pos  = p;
    p1         = a;
    p2         = b;
    game_state = s;
    exp_q.push_back(model_pixel(p, a, b, s));
    name_q.push_back(name);
  endtask

  task automatic drain_pixels();
    logic [7:0] exp_px;
    string      exp_name;
    while (exp_q.size() > 0) begin
      @(posedge clk);
      #1;
      exp_px   = exp_q.pop_front();
      exp_name = name_q.pop_front();
      check_pixel(exp_name, exp_px);
    end
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    seed       = 16254;
    pixel_pos  = '0;
    p1         = '0;
    p2         = '0;
    game_state = fight_pkg::S_FIGHT; // Screen stays black only through the reset state
    wb_req     = '0;
    @(negedge reset);
    game_state = fight_pkg::S_IDLE;

    for (int i = 0; i < 4; i++) begin
      @(posedge clk);
      #1;
      check_pixel("reset", fight_pkg::BG_COLOR);
    end

    for (int i = 0; i < 8192; i++) begin
      rnd     = $random(seed);
      wr_byte = (rnd[9:8] == 2'b00) ? fight_pkg::TRANSPARENT_COLOR : rnd[7:0]; // Quarter magenta
      sprite_model[13'(i)] = wr_byte;
      bus_access(1'b1, 13'(i), wr_byte, rd_byte);
    end
    for (int i = 0; i < 64; i++) begin
      rnd    = $random(seed);
      rd_adr = rnd[12:0];
      bus_access(1'b0, rd_adr, 8'h00, rd_byte);
      assert (rd_byte === sprite_model[rd_adr]) else begin
        err_mismatch++;
        $display("MISMATCH readback: expected %02h, actual %02h", sprite_model[rd_adr], rd_byte);
      end
    end

    for (int i = 0; i < 3000; i++) begin
      pa = rand_player(1'b1);
      pb = rand_player(1'b1);
      if (rand_below(2) == 0) begin // Overlapping sprites
        pb.x = clamp_coord(int'(pa.x) + rand_below(65) - 32, 576);
        pb.y = clamp_coord(int'(pa.y) + rand_below(65) - 32, 416);
      end
      case (rand_below(3))
        0: pos = rand_pos();
        1: begin
          pos.x = clamp_coord(int'(pa.x) + rand_below(72) - 4, 639);
          pos.y = clamp_coord(int'(pa.y) + rand_below(72) - 4, 479);
        end
        default: begin
          pos.x = clamp_coord(int'(pb.x) + rand_below(72) - 4, 639);
          pos.y = clamp_coord(int'(pb.y) + rand_below(72) - 4, 479);
        end
      endcase
      pixel_step(pos, pa, pb, fight_pkg::S_FIGHT, "sprites");
    end

    for (int i = 0; i < 600; i++) begin
      pa      = rand_player(1'b0); // Invalid pose leaves only the boxes
      pb      = rand_player(1'b0);
      row_top = (rand_below(2) == 0) ? fight_pkg::BOX_OFFSET
                : fight_pkg::SCREEN_H - fight_pkg::BOX_OFFSET - fight_pkg::BOX_SIZE;
      k       = rand_below(3);
      slot_x  = (rand_below(2) == 0) ? fight_pkg::BOX_OFFSET + k * fight_pkg::BOX_PITCH
                : fight_pkg::SCREEN_W - fight_pkg::BOX_OFFSET - fight_pkg::BOX_SIZE
                  - k * fight_pkg::BOX_PITCH;
      pos.x   = clamp_coord(slot_x + rand_below(fight_pkg::BOX_SIZE + 10) - 5, 639);
      pos.y   = clamp_coord(row_top + rand_below(fight_pkg::BOX_SIZE + 10) - 5, 479);
      pixel_step(pos, pa, pb, fight_pkg::S_FIGHT, "boxes");
    end

    for (int s = 0; s < 5; s++) begin
      for (int i = 0; i < 40; i++) begin
        pixel_step(rand_pos(), rand_player(1'b1), rand_player(1'b1), other_states[s],
                   "non_fight");
      end
    end
    for (int i = 0; i < 100; i++) begin
      st = (rand_below(2) == 0) ? fight_pkg::S_FIGHT : other_states[3'(rand_below(5))];
      pixel_step(rand_pos(), rand_player(1'b1), rand_player(1'b1), st, "state_switch");
    end
    drain_pixels();

    $display("Errors: %0d mismatches, %0d other", err_mismatch, err_other);
    if (err_mismatch + err_other == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/clock_gen.sv
`default_nettype none

module clock_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk; // Period of 10
  end

  initial begin
    reset = 1'b1;
    repeat (16) @(posedge clk);
    #1 reset = 1'b0; // Released just after the edge, like the other inputs
  end

endmodule

`default_nettype wire

//--- rtl/fight_renderer.sv
`default_nettype none

module fight_renderer (
  input  logic                          clk,
  input  logic                          reset,
  input  fight_pkg::pixel_pos_t         pixel_pos,
  input  fight_pkg::player_t            p1,
  input  fight_pkg::player_t            p2,
  input  fight_pkg::game_state_t        game_state,
  input  fight_pkg::wb_req_t            wb_req,
  output fight_pkg::wb_rsp_t            wb_rsp,
  output logic [fight_pkg::COLOR_W-1:0] pixel_data
);

  logic [fight_pkg::SPRITE_ADDR_W-1:0] addr_p1;
  logic [fight_pkg::SPRITE_ADDR_W-1:0] addr_p2;
  logic [fight_pkg::COLOR_W-1:0]       data_p1;
  logic [fight_pkg::COLOR_W-1:0]       data_p2;
  logic                                hit_p1;
  logic                                hit_p2;
  logic                                heart_hit;
  logic                                block_hit;

  player_fetch i_fetch_p1 (
    .clk        (clk),
    .reset      (reset),
    .pixel_pos  (pixel_pos),
    .player     (p1),
    .player_sel (1'b0), // Lower half of the sprite memory
    .rd_addr    (addr_p1),
    .hit        (hit_p1)
  );

  player_fetch i_fetch_p2 (
    .clk        (clk),
    .reset      (reset),
    .pixel_pos  (pixel_pos),
    .player     (p2),
    .player_sel (1'b1),
    .rd_addr    (addr_p2),
    .hit        (hit_p2)
  );

  sprite_ram i_sprite_ram (
    .clk       (clk),
    .reset     (reset),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .rd_addr_a (addr_p1),
    .rd_addr_b (addr_p2),
    .rd_data_a (data_p1),
    .rd_data_b (data_p2)
  );

  hud_boxes i_hud_boxes (
    .clk       (clk),
    .reset     (reset),
    .pixel_pos (pixel_pos),
    .health_p1 (p1.health),
    .health_p2 (p2.health),
    .block_p1  (p1.block),
    .block_p2  (p2.block),
    .heart_hit (heart_hit),
    .block_hit (block_hit)
  );

  pixel_compositor i_compositor (
    .clk        (clk),
    .reset      (reset),
    .game_state (game_state),
    .heart_hit  (heart_hit),
    .block_hit  (block_hit),
    .hit_p1     (hit_p1),
    .hit_p2     (hit_p2),
    .sprite_p1  (data_p1),
    .sprite_p2  (data_p2),
    .pixel_data (pixel_data)
  );

endmodule

`default_nettype wire

//--- rtl/pixel_compositor.sv
`default_nettype none

module pixel_compositor (
  input  logic                          clk,
  input  logic                          reset,
  input  fight_pkg::game_state_t        game_state,
  input  logic                          heart_hit,
  input  logic                          block_hit,
  input  logic                          hit_p1,
  input  logic                          hit_p2,
  input  logic [fight_pkg::COLOR_W-1:0] sprite_p1,
  input  logic [fight_pkg::COLOR_W-1:0] sprite_p2,
  output logic [fight_pkg::COLOR_W-1:0] pixel_data
);

  fight_pkg::game_state_t        state_q;
  logic [fight_pkg::COLOR_W-1:0] pixel_c;

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= fight_pkg::S_IDLE;
    end else begin
      state_q <= game_state; // Same stage as the flags and memory data
    end
  end

  always_comb begin
    case (state_q)
      fight_pkg::S_FIGHT: begin
        if (heart_hit) pixel_c = fight_pkg::HEART_COLOR;
        else if (block_hit) pixel_c = fight_pkg::BLOCK_COLOR;
        else if (hit_p1 && sprite_p1 != fight_pkg::TRANSPARENT_COLOR) pixel_c = sprite_p1;
        else if (hit_p2 && sprite_p2 != fight_pkg::TRANSPARENT_COLOR) pixel_c = sprite_p2;
        else pixel_c = fight_pkg::TRANSPARENT_COLOR; // Background shows through
      end
      default: pixel_c = fight_pkg::BG_COLOR; // Menu, countdown and result screens
    endcase
  end

  always_ff @(posedge clk) begin
    pixel_data <= pixel_c;
  end

  a_state_defined: assert property (
    @(posedge clk) disable iff (reset)
    state_q inside {fight_pkg::S_IDLE, fight_pkg::S_COUNTDOWN, fight_pkg::S_FIGHT,
                    fight_pkg::S_P1_WIN, fight_pkg::S_P2_WIN, fight_pkg::S_EQ}
  );

endmodule

`default_nettype wire

//--- rtl/hud_boxes.sv
`default_nettype none

module hud_boxes (
  input  logic                  clk,
  input  logic                  reset,
  input  fight_pkg::pixel_pos_t pixel_pos,
  input  logic [2:0]            health_p1,
  input  logic [2:0]            health_p2,
  input  logic [2:0]            block_p1,
  input  logic [2:0]            block_p2,
  output logic                  heart_hit,
  output logic                  block_hit
);

  logic                            heart_row;
  logic                            block_row;
  logic [fight_pkg::BOX_SLOTS-1:0] col_p1;
  logic [fight_pkg::BOX_SLOTS-1:0] col_p2;
  logic [fight_pkg::BOX_SLOTS-1:0] lit_heart;
  logic [fight_pkg::BOX_SLOTS-1:0] lit_block;

  function automatic logic in_span(input logic [fight_pkg::COORD_W-1:0] pos,
                                   input int start);
    return (int'(pos) >= start) && (int'(pos) < start + fight_pkg::BOX_SIZE);
  endfunction

  assign heart_row = in_span(pixel_pos.y, fight_pkg::BOX_OFFSET);
  assign block_row = in_span(pixel_pos.y,
                             fight_pkg::SCREEN_H - fight_pkg::BOX_OFFSET - fight_pkg::BOX_SIZE);

  // Player 1 grows rightwards from the left edge, player 2 leftwards from the right
  for (genvar k = 0; k < fight_pkg::BOX_SLOTS; k++) begin : g_slot
    assign col_p1[k] = in_span(pixel_pos.x, fight_pkg::BOX_OFFSET + k * fight_pkg::BOX_PITCH);
    assign col_p2[k] = in_span(pixel_pos.x, fight_pkg::SCREEN_W - fight_pkg::BOX_OFFSET
                                            - fight_pkg::BOX_SIZE - k * fight_pkg::BOX_PITCH);

    assign lit_heart[k] = (col_p1[k] && int'(health_p1) > k)
                       || (col_p2[k] && int'(health_p2) > k);
    assign lit_block[k] = (col_p1[k] && int'(block_p1) > k)
                       || (col_p2[k] && int'(block_p2) > k);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      heart_hit <= 1'b0;
      block_hit <= 1'b0;
    end else begin
      heart_hit <= heart_row && (|lit_heart); // Top row
      block_hit <= block_row && (|lit_block); // Bottom row
    end
  end

endmodule

`default_nettype wire

//--- rtl/player_fetch.sv
`default_nettype none

module player_fetch (
  input  logic                                clk,
  input  logic                                reset,
  input  fight_pkg::pixel_pos_t               pixel_pos,
  input  fight_pkg::player_t                  player,
  input  logic                                player_sel,
  output logic [fight_pkg::SPRITE_ADDR_W-1:0] rd_addr,
  output logic                                hit
);

  logic [fight_pkg::COORD_W-1:0] rel_x;
  logic [fight_pkg::COORD_W-1:0] rel_y;
  logic                          pose_valid;
  logic                          hit_c;

  // Offsets inside the sprite window, meaningful only when hit_c
  assign rel_x = pixel_pos.x - player.x;
  assign rel_y = pixel_pos.y - player.y;

  assign pose_valid = int'(player.pose) < fight_pkg::POSE_COUNT;

  assign hit_c = pose_valid
              && (pixel_pos.x >= player.x) && (int'(rel_x) < fight_pkg::SPRITE_DIM)
              && (pixel_pos.y >= player.y) && (int'(rel_y) < fight_pkg::SPRITE_DIM);

  // Drop the scale bits to land on a 16x16 frame pixel
  assign rd_addr = {player_sel, player.pose,
                    rel_y[fight_pkg::SPRITE_SCALE_SHIFT +: $clog2(fight_pkg::FRAME_DIM)],
                    rel_x[fight_pkg::SPRITE_SCALE_SHIFT +: $clog2(fight_pkg::FRAME_DIM)]};

  always_ff @(posedge clk) begin
    if (reset) begin
      hit <= 1'b0;
    end else begin
      hit <= hit_c; // Lines up with the memory read data
    end
  end

  a_hit_pose_valid: assert property (
    @(posedge clk) disable iff (reset)
    hit |-> int'($past(player.pose)) < fight_pkg::POSE_COUNT
  );

endmodule

`default_nettype wire

//--- rtl/sprite_ram.sv
`default_nettype none

module sprite_ram (
  input  logic                                clk,
  input  logic                                reset,
  input  fight_pkg::wb_req_t                  wb_req,
  output fight_pkg::wb_rsp_t                  wb_rsp,
  input  logic [fight_pkg::SPRITE_ADDR_W-1:0] rd_addr_a,
  input  logic [fight_pkg::SPRITE_ADDR_W-1:0] rd_addr_b,
  output logic [fight_pkg::COLOR_W-1:0]       rd_data_a,
  output logic [fight_pkg::COLOR_W-1:0]       rd_data_b
);

  logic [fight_pkg::COLOR_W-1:0] mem [0:(1 << fight_pkg::SPRITE_ADDR_W)-1];
  logic                          ack_q;
  logic [fight_pkg::COLOR_W-1:0] dat_r_q;
  logic                          bus_take;

  assign bus_take = wb_req.cyc && wb_req.stb && !ack_q; // New cycle, not yet answered

  always_ff @(posedge clk) begin
    if (reset) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= bus_take;
    end
  end

  // Bus port shares the write edge with the ack
  always_ff @(posedge clk) begin
    if (bus_take) begin
      dat_r_q <= mem[wb_req.adr];
      if (wb_req.we) begin
        mem[wb_req.adr] <= wb_req.dat_w;
      end
    end
  end

  // Pixel read ports see the old byte on a write collision
  always_ff @(posedge clk) begin
    rd_data_a <= mem[rd_addr_a]; // Player 1 frame
    rd_data_b <= mem[rd_addr_b]; // Player 2 frame
  end

  assign wb_rsp.ack   = ack_q;
  assign wb_rsp.dat_r = dat_r_q;

  a_ack_single: assert property (
    @(posedge clk) disable iff (reset)
    wb_rsp.ack |=> !wb_rsp.ack
  );

endmodule

`default_nettype wire

//--- rtl/fight_pkg.sv
`default_nettype none

package fight_pkg;

  localparam int SCREEN_W = 640;
  localparam int SCREEN_H = 480;
  localparam int COORD_W  = 10;
  localparam int COLOR_W  = 8;

  localparam logic [COLOR_W-1:0] TRANSPARENT_COLOR = 8'hE3; // Magenta
  localparam logic [COLOR_W-1:0] BG_COLOR          = 8'h00;
  localparam logic [COLOR_W-1:0] HEART_COLOR       = 8'hE0; // Red
  localparam logic [COLOR_W-1:0] BLOCK_COLOR       = 8'h03; // Blue

  localparam int FRAME_DIM          = 16;
  localparam int SPRITE_SCALE_SHIFT = 2;
  localparam int SPRITE_DIM         = FRAME_DIM << SPRITE_SCALE_SHIFT;
  localparam int POSE_COUNT         = 11;
  localparam int SPRITE_ADDR_W      = 13; // Player, pose, row, column

  localparam int BOX_SIZE   = 50;
  localparam int BOX_OFFSET = 40;
  localparam int BOX_PITCH  = 70;
  localparam int BOX_SLOTS  = 3;

  typedef enum logic [2:0] {
    S_IDLE      = 3'd0,
    S_COUNTDOWN = 3'd1,
    S_FIGHT     = 3'd2,
    S_P1_WIN    = 3'd3,
    S_P2_WIN    = 3'd4,
    S_EQ        = 3'd5
  } game_state_t;

  // Codes 11 to 15 select no frame
  typedef enum logic [3:0] {
    POSE_IDLE             = 4'd0,
    POSE_WALK             = 4'd1,
    POSE_WALK_BACK        = 4'd2,
    POSE_ATTACK_START     = 4'd3,
    POSE_ATTACK_END       = 4'd4,
    POSE_ATTACK_PULL      = 4'd5,
    POSE_DIR_ATTACK_START = 4'd6,
    POSE_DIR_ATTACK_END   = 4'd7,
    POSE_DIR_ATTACK_PULL  = 4'd8,
    POSE_GOT_HIT          = 4'd9,
    POSE_BLOCK            = 4'd10
  } pose_t;

  typedef struct packed {
    logic [COORD_W-1:0] x;
    logic [COORD_W-1:0] y;
  } pixel_pos_t;

  typedef struct packed {
    logic [COORD_W-1:0] x; // Sprite top left corner
    logic [COORD_W-1:0] y;
    pose_t              pose;
    logic [2:0]         health;
    logic [2:0]         block;
  } player_t;

  typedef struct packed {
    logic                     cyc;
    logic                     stb;
    logic                     we;
    logic [SPRITE_ADDR_W-1:0] adr;
    logic [COLOR_W-1:0]       dat_w;
  } wb_req_t;

  typedef struct packed {
    logic               ack;
    logic [COLOR_W-1:0] dat_r;
  } wb_rsp_t;

endpackage

`default_nettype wire
